/* src/adc_const_pkg.sv */
package adc_const_pkg;

    // one ADC sample, two's complement
    localparam int n_adc = 8;

    // samples packed side by side into one memory word
    localparam int n_mem_width = 4;

    // word address bits inside a single tile
    localparam int n_mem_addr = 4;

    // tile count and the bits that pick a tile
    localparam int n_mem_tiles = 4;
    localparam int n_tile_bits = $clog2(n_mem_tiles);

    // tile index in the upper bits, word address in the lower bits
    localparam int n_sys_addr = n_mem_addr + n_tile_bits;

    typedef logic signed [n_adc-1:0] adc_sample_t;

    typedef logic [n_sys_addr-1:0] sys_addr_t;

    // last word of the capture, all ones
    localparam sys_addr_t max_addr = '1;

    // lane 0 sits in the low bits
    typedef struct packed {
        adc_sample_t [n_mem_width-1:0] lane;
    } sample_word_t;

endpackage

/* src/capture_pkg.sv */
package capture_pkg;

    // credits the consumer hands out after reset
    localparam int readout_credits = 4;

    // holds 0 up to readout_credits
    typedef logic [$clog2(readout_credits + 1)-1:0] credit_cnt_t;

    // write burst progress
    // writing while the burst runs, done after the last word
    // until start_write is released
    typedef struct packed {
        logic writing;
        logic done;
    } capture_status_t;

    // one readout beat towards the consumer
    // last marks the beat for the final address
    typedef struct packed {
        logic                       valid;
        logic                       last;
        adc_const_pkg::sys_addr_t    addr;
        adc_const_pkg::sample_word_t data;
    } stream_beat_t;

endpackage

/* src/sram_tile.sv */
`timescale 1ns/1ps

module sram_tile (
    input  logic                                clk,
    input  logic                                web,
    input  logic [adc_const_pkg::n_mem_addr-1:0] a,
    input  adc_const_pkg::sample_word_t         d,
    output adc_const_pkg::sample_word_t         q
);

    // storage, one sample word per address
    adc_const_pkg::sample_word_t mem [2**adc_const_pkg::n_mem_addr];

    // write port, active low enable
    always_ff @(posedge clk) begin
        if (web == 1'b0) begin
            mem[a] <= d;
        end
    end

    // registered read on every edge
    // a write to the same address returns the old word
    always_ff @(posedge clk) begin
        q <= mem[a];
    end

    // a write to an unknown address would corrupt the whole tile
    a_addr_known_on_write: assert property (
        @(posedge clk) (web == 1'b0) |-> !$isunknown(a)
    ) else $error("sram_tile write with unknown address %b", a);

endmodule

/* src/oneshot_multimemory.sv */
`timescale 1ns/1ps

module oneshot_multimemory (
    input  logic                            clk,
    input  logic                            rstb,
    input  adc_const_pkg::sample_word_t     in_bytes,
    input  logic                            in_start_write,
    input  adc_const_pkg::sys_addr_t        in_addr,
    output adc_const_pkg::sample_word_t     out_data,
    output adc_const_pkg::sys_addr_t        addr,
    output capture_pkg::capture_status_t    status
);

    typedef enum logic [1:0] {
        st_wait,
        st_write,
        st_done
    } state_t;

    state_t state;

    adc_const_pkg::sys_addr_t write_addr;
    adc_const_pkg::sys_addr_t cur_addr;

    logic wr_active;

    logic [adc_const_pkg::n_tile_bits-1:0] cur_tile;
    logic [adc_const_pkg::n_tile_bits-1:0] rd_tile;
    logic [adc_const_pkg::n_mem_addr-1:0]  tile_addr;

    logic [adc_const_pkg::n_mem_tiles-1:0] tile_sel;
    logic [adc_const_pkg::n_mem_tiles-1:0] tile_web;

    adc_const_pkg::sample_word_t tile_q [adc_const_pkg::n_mem_tiles];

    // one-shot write burst
    // waits for start, writes every address once, then holds until
    // the request drops so a level start cannot retrigger
    always_ff @(posedge clk) begin
        if (!rstb) begin
            state      <= st_wait;
            write_addr <= '0;
        end else begin
            case (state)
                st_wait: begin
                    if (in_start_write) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (write_addr == adc_const_pkg::max_addr) begin
                        state <= st_done;
                    end else begin
                        write_addr <= write_addr + 1'b1;
                    end
                end
                st_done: begin
                    if (!in_start_write) begin
                        state      <= st_wait;
                        write_addr <= '0;
                    end
                end
                default: begin
                    state      <= st_wait;
                    write_addr <= '0;
                end
            endcase
        end
    end

    assign wr_active = (state == st_write);

    always_comb begin
        status.writing = wr_active;
        status.done    = (state == st_done);
    end

    assign addr = write_addr;

    // writer owns the tiles during the burst, reader otherwise
    assign cur_addr  = wr_active ? write_addr : in_addr;
    assign cur_tile  = cur_addr[adc_const_pkg::n_sys_addr-1:adc_const_pkg::n_mem_addr];
    assign tile_addr = cur_addr[adc_const_pkg::n_mem_addr-1:0];

    // tile index follows the access by one cycle, same as the tile q
    always_ff @(posedge clk) begin
        rd_tile <= cur_tile;
    end

    assign out_data = tile_q[rd_tile];

    for (genvar gi = 0; gi < adc_const_pkg::n_mem_tiles; gi++) begin : g_tile
        // one-hot decode of the upper address bits
        assign tile_sel[gi] = (cur_tile == gi[adc_const_pkg::n_tile_bits-1:0]);
        assign tile_web[gi] = ~(wr_active & tile_sel[gi]);

        sram_tile u_tile (
            .clk (clk),
            .web (tile_web[gi]),
            .a   (tile_addr),
            .d   (in_bytes),
            .q   (tile_q[gi])
        );
    end

    // no address skipped or repeated during the burst
    a_addr_step: assert property (
        @(posedge clk) disable iff (!rstb)
        (wr_active && write_addr != adc_const_pkg::max_addr)
            |=> (write_addr == $past(write_addr) + 1'b1)
    ) else $error("write address did not step by one");

    a_one_tile_written: assert property (
        @(posedge clk) disable iff (!rstb)
        $onehot0(~tile_web)
    ) else $error("more than one tile write enable active: %b", ~tile_web);

    a_status_exclusive: assert property (
        @(posedge clk) disable iff (!rstb)
        !(status.writing && status.done)
    ) else $error("writing and done both high");

endmodule

/* src/readout_streamer.sv */
`timescale 1ns/1ps

module readout_streamer (
    input  logic                            clk,
    input  logic                            rstb,
    input  logic                            read_start,
    input  logic                            credit_return,
    input  capture_pkg::capture_status_t    status,
    input  adc_const_pkg::sample_word_t     rd_data,
    output adc_const_pkg::sys_addr_t        rd_addr,
    output capture_pkg::stream_beat_t       beat
);

    capture_pkg::credit_cnt_t credits;

    adc_const_pkg::sys_addr_t next_addr;
    adc_const_pkg::sys_addr_t addr_q;

    logic active;
    logic issue;
    logic valid_q;
    logic last_q;

    // a read goes out only with a credit in hand
    assign issue   = active && (credits != '0);
    assign rd_addr = next_addr;

    // one credit per issued read, one back per return pulse
    always_ff @(posedge clk) begin
        if (!rstb) begin
            credits <= capture_pkg::credit_cnt_t'(capture_pkg::readout_credits);
        end else begin
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // address walk over the whole capture
    // start only once the burst is complete and nothing is running
    always_ff @(posedge clk) begin
        if (!rstb) begin
            active    <= 1'b0;
            next_addr <= '0;
        end else if (!active) begin
            if (read_start && status.done) begin
                active    <= 1'b1;
                next_addr <= '0;
            end
        end else if (issue) begin
            if (next_addr == adc_const_pkg::max_addr) begin
                active <= 1'b0;
            end else begin
                next_addr <= next_addr + 1'b1;
            end
        end
    end

    // beat tags trail the read address by the memory latency
    always_ff @(posedge clk) begin
        if (!rstb) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= issue;
            last_q  <= issue && (next_addr == adc_const_pkg::max_addr);
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= next_addr;
    end

    // data comes straight from the memory, already one cycle late
    always_comb begin
        beat.valid = valid_q;
        beat.last  = last_q;
        beat.addr  = addr_q;
        beat.data  = rd_data;
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstb)
        credits <= capture_pkg::credit_cnt_t'(capture_pkg::readout_credits)
    ) else $error("credit count %0d above limit", credits);

    // consumer holds nothing, so a return here is a protocol error
    a_no_extra_return: assert property (
        @(posedge clk) disable iff (!rstb)
        !(credit_return &&
          credits == capture_pkg::credit_cnt_t'(capture_pkg::readout_credits))
    ) else $error("credit returned while all credits are held");

    // every delivered beat was paid for with a credit
    a_beat_had_credit: assert property (
        @(posedge clk) disable iff (!rstb)
        beat.valid |-> ($past(credits) != '0)
    ) else $error("beat issued without credit");

endmodule

/* src/capture_top.sv */
`timescale 1ns/1ps

module capture_top (
    input  logic                            clk,
    input  logic                            rstb,
    input  adc_const_pkg::sample_word_t     adc_in,
    input  logic                            start_write,
    input  logic                            read_start,
    input  logic                            credit_return,
    output capture_pkg::capture_status_t    status,
    output adc_const_pkg::sys_addr_t        write_addr,
    output capture_pkg::stream_beat_t       beat
);

    // read path between streamer and memory
    adc_const_pkg::sys_addr_t    rd_addr;
    adc_const_pkg::sample_word_t rd_data;

    // capture memory, also exports the burst status
    oneshot_multimemory u_mem (
        .clk            (clk),
        .rstb           (rstb),
        .in_bytes       (adc_in),
        .in_start_write (start_write),
        .in_addr        (rd_addr),
        .out_data       (rd_data),
        .addr           (write_addr),
        .status         (status)
    );

    // credit-paced read-back
    readout_streamer u_stream (
        .clk           (clk),
        .rstb          (rstb),
        .read_start    (read_start),
        .credit_return (credit_return),
        .status        (status),
        .rd_data       (rd_data),
        .rd_addr       (rd_addr),
        .beat          (beat)
    );

endmodule

/* dv/capture_tb.sv */
`timescale 1ns/1ps

module capture_tb;

    localparam int clk_period = 4;
    localparam int n_words = 2**adc_const_pkg::n_sys_addr;
    localparam int n_tests = 6;
    // one capture plus a readout at one beat per 8 cycles
    localparam int test_budget = n_words + n_words * 8;
    localparam int watchdog_cycles = n_tests * test_budget + 400;
    localparam int quiet_cycles = 16;
    localparam logic [15:0] lfsr_seed = 16'd34346;
    localparam logic [15:0] lfsr_taps = 16'hB400;

    logic                           clk;
    logic                           rstb;
    adc_const_pkg::sample_word_t    adc_in;
    logic                           start_write;
    logic                           read_start;
    logic                           credit_return;
    capture_pkg::capture_status_t   status;
    adc_const_pkg::sys_addr_t       write_addr;
    capture_pkg::stream_beat_t      beat;

    logic [15:0] lfsr_state;

    // expected memory contents recorded during each burst
    adc_const_pkg::sample_word_t ref_mem [n_words];
    adc_const_pkg::sample_word_t old_mem [n_words];

    string test_name = "startup";
    logic  expect_beats;
    int    outstanding;
    int    write_count = 0;
    logic  prev_writing = 1'b0;
    int    total_beats = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    errors_at_start = 0;

    adc_const_pkg::sys_addr_t expect_addr = '0;

    int stim_errors = 0;
    int write_errors = 0;
    int read_errors = 0;
    int credit_errors = 0;
    int assert_errors = 0;

    capture_top dut (
        .clk           (clk),
        .rstb          (rstb),
        .adc_in        (adc_in),
        .start_write   (start_write),
        .read_start    (read_start),
        .credit_return (credit_return),
        .status        (status),
        .write_addr    (write_addr),
        .beat          (beat)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ lfsr_taps;
        end
        return n;
    endfunction

    // one LFSR step per bit
    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic int total_errors();
        return stim_errors + write_errors + read_errors + credit_errors + assert_errors;
    endfunction

    // ADC samples and the credit-returning consumer
    initial begin : source
        logic [31:0] bits;
        lfsr_state = lfsr_seed;
        adc_in = '0;
        credit_return = 1'b0;
        outstanding = 0;
        forever begin
            @(posedge clk);
            draw_bits(32, bits);
            adc_in <= adc_const_pkg::sample_word_t'(bits);
            if (!rstb) begin
                outstanding = 0;
                credit_return <= 1'b0;
            end else begin
                // each beat hands over a credit and each return gives one back
                if (beat.valid) begin
                    outstanding = outstanding + 1;
                end
                if (credit_return) begin
                    outstanding = outstanding - 1;
                end
                if (outstanding > capture_pkg::readout_credits) begin
                    credit_errors++;
                    $display("%s: consumer holds %0d credits, more than the %0d granted",
                             test_name, outstanding, capture_pkg::readout_credits);
                end
                // single random bit throttles the returns
                draw_bits(1, bits);
                credit_return <= (outstanding > 0) && bits[0];
            end
        end
    end

    // reference capture and write address walk
    always @(posedge clk) begin
        if (rstb) begin
            if (status.writing) begin
                ref_mem[write_addr] = adc_in;
                if (int'(write_addr) != write_count) begin
                    write_errors++;
                    $display("Mismatch %s write_addr expected %0d actual %0d",
                             test_name, write_count, write_addr);
                end
                write_count++;
            end else if (prev_writing) begin
                if (write_count != n_words) begin
                    write_errors++;
                    $display("Mismatch %s writes per burst expected %0d actual %0d",
                             test_name, n_words, write_count);
                end
                write_count = 0;
            end
            prev_writing = status.writing;
        end
    end

    // beat order, data and last flag
    always @(posedge clk) begin
        if (rstb && beat.valid) begin
            if (beat.addr !== expect_addr) begin
                read_errors++;
                $display("Mismatch %s beat addr expected %0d actual %0d",
                         test_name, expect_addr, beat.addr);
            end
            if (beat.data !== ref_mem[expect_addr]) begin
                read_errors++;
                $display("Mismatch %s data at %0d expected %h actual %h",
                         test_name, expect_addr, ref_mem[expect_addr], beat.data);
            end
            if (beat.last !== (expect_addr == adc_const_pkg::max_addr)) begin
                read_errors++;
                $display("Mismatch %s last at %0d expected %b actual %b", test_name,
                         expect_addr, (expect_addr == adc_const_pkg::max_addr), beat.last);
            end
            // the walk wraps to 0 for the next readout
            expect_addr = expect_addr + 1'b1;
            total_beats <= total_beats + 1;
        end
    end

    a_start_writes: assert property (
        @(posedge clk) disable iff (!rstb)
        (!status.writing && !status.done && start_write) |=> status.writing
    ) else begin
        assert_errors++;
        $display("%s: writing did not rise one edge after start_write", test_name);
    end

    a_last_write: assert property (
        @(posedge clk) disable iff (!rstb)
        (status.writing && write_addr == adc_const_pkg::max_addr)
            |=> (!status.writing && status.done)
    ) else begin
        assert_errors++;
        $display("%s: burst did not end with done after the last address", test_name);
    end

    // a level start must not retrigger while done
    a_done_holds: assert property (
        @(posedge clk) disable iff (!rstb)
        (status.done && start_write) |=> (status.done && !status.writing)
    ) else begin
        assert_errors++;
        $display("%s: done dropped or a new burst began while start_write held", test_name);
    end

    a_done_clears: assert property (
        @(posedge clk) disable iff (!rstb)
        (status.done && !start_write) |=> (!status.done && !status.writing)
    ) else begin
        assert_errors++;
        $display("%s: done did not clear after start_write was released", test_name);
    end

    a_beats_expected: assert property (
        @(posedge clk) disable iff (!rstb)
        beat.valid |-> expect_beats
    ) else begin
        assert_errors++;
        $display("%s: beat delivered although no readout was accepted", test_name);
    end

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test();
        int new_errors;
        new_errors = total_errors() - errors_at_start;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, new_errors);
        end
    endtask

    task automatic pulse_read_start();
        @(posedge clk);
        read_start <= 1'b1;
        @(posedge clk);
        read_start <= 1'b0;
    endtask

    task automatic wait_for_done(input logic level);
        int cycles;
        cycles = 0;
        while (status.done != level && cycles < test_budget) begin
            @(posedge clk);
            cycles++;
        end
        if (status.done != level) begin
            stim_errors++;
            $display("%s: done did not reach %b within %0d cycles",
                     test_name, level, test_budget);
        end
    endtask

    task automatic run_readout(input logic extra_pulse);
        int   start_beats;
        int   cycles;
        logic pulsed;
        start_beats = total_beats;
        cycles = 0;
        pulsed = 1'b0;
        expect_beats = 1'b1;
        pulse_read_start();
        while (total_beats - start_beats < n_words && cycles < test_budget) begin
            @(posedge clk);
            cycles++;
            // a second request mid-stream must not restart the walk
            if (extra_pulse && !pulsed && total_beats - start_beats >= 10) begin
                read_start <= 1'b1;
                pulsed = 1'b1;
            end else begin
                read_start <= 1'b0;
            end
        end
        @(posedge clk);
        read_start <= 1'b0;
        // watch for stray beats past the end
        repeat (quiet_cycles) @(posedge clk);
        if (total_beats - start_beats != n_words) begin
            stim_errors++;
            $display("Mismatch %s beat count expected %0d actual %0d",
                     test_name, n_words, total_beats - start_beats);
        end
        expect_beats = 1'b0;
    endtask

    initial begin : stimulus
        int diff_words;
        rstb = 1'b0;
        start_write = 1'b0;
        read_start = 1'b0;
        expect_beats = 1'b0;
        repeat (3) @(posedge clk);
        rstb <= 1'b1;

        begin_test("reset_values");
        @(posedge clk);
        if (status !== '0) begin
            stim_errors++;
            $display("Mismatch %s status expected 00 actual %b", test_name, status);
        end
        if (beat.valid !== 1'b0) begin
            stim_errors++;
            $display("Mismatch %s beat.valid expected 0 actual %b", test_name, beat.valid);
        end
        if (write_addr !== '0) begin
            stim_errors++;
            $display("Mismatch %s write_addr expected 0 actual %0d", test_name, write_addr);
        end
        end_test();

        begin_test("read_before_capture");
        pulse_read_start();
        repeat (quiet_cycles) @(posedge clk);
        end_test();

        begin_test("write_burst");
        @(posedge clk);
        start_write <= 1'b1;
        // readout request in the middle of the burst
        repeat (8) @(posedge clk);
        pulse_read_start();
        wait_for_done(1'b1);
        end_test();

        begin_test("hold_after_done");
        repeat (quiet_cycles) @(posedge clk);
        if (write_addr != adc_const_pkg::max_addr) begin
            stim_errors++;
            $display("Mismatch %s write_addr expected %0d actual %0d",
                     test_name, adc_const_pkg::max_addr, write_addr);
        end
        end_test();

        begin_test("throttled_readout");
        run_readout(1'b1);
        end_test();

        begin_test("recapture");
        for (int i = 0; i < n_words; i++) begin
            old_mem[i] = ref_mem[i];
        end
        @(posedge clk);
        start_write <= 1'b0;
        wait_for_done(1'b0);
        @(posedge clk);
        start_write <= 1'b1;
        wait_for_done(1'b1);
        diff_words = 0;
        for (int i = 0; i < n_words; i++) begin
            if (ref_mem[i] != old_mem[i]) begin
                diff_words++;
            end
        end
        if (diff_words == 0) begin
            stim_errors++;
            $display("%s: second capture holds the same data as the first", test_name);
        end
        run_readout(1'b0);
        start_write <= 1'b0;
        end_test();

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
src/adc_const_pkg.sv
src/capture_pkg.sv
src/sram_tile.sv
src/oneshot_multimemory.sv
src/readout_streamer.sv
src/capture_top.sv
dv/capture_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the capture testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=capture_sim
log_file=sim.log

verilator --binary --timing --assert \
    --top-module capture_tb \
    -Mdir "$build_dir" -o "$sim_bin" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the log decides
if grep -qx "RESULT: PASS" "$log_file"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $log_file"
exit 1
